// ==== nes_input_pkg.sv ====
`default_nettype none

package nes_input_pkg;

  // serial frame length of one controller port
  localparam int unsigned frame_bits = 24;

  // one pad from bit 0 up as A, B, select, start, up, down, left and right
  // a 1 means the button is pressed
  typedef logic [7:0] pad_buttons_t;

  // full frame as shifted out on one port lsb first
  typedef logic [frame_bits-1:0] joy_frame_t;

  // post-download reset hold counter
  typedef logic [7:0] hold_count_t;

  // boot and reset sequencing states
  typedef enum logic [1:0] {
    boot_wait,
    loading,
    settle,
    running
  } boot_state_t;

  // counter load value while a download is in progress
  localparam hold_count_t download_hold_cycles = 8'd255;

  // multitap signature bytes sent in frame bits 16 to 23
  localparam pad_buttons_t tap_signature_port1 = 8'h08;
  localparam pad_buttons_t tap_signature_port2 = 8'h04;

  // upper frame bits when no multitap is attached
  // a plain pad reports ones after its eight buttons
  localparam logic [frame_bits-9:0] no_tap_fill = '1;

endpackage

`default_nettype wire

// ==== boot_reset_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module boot_reset_fsm (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic downloading,
  input  logic hold_active,
  input  logic loader_fail,
  input  logic user_reset,
  output logic core_reset,
  output logic loader_reset
);

  nes_input_pkg::boot_state_t state;
  nes_input_pkg::boot_state_t state_next;

  // previous downloading sample for the loader reset pulse
  logic downloading_q;

  always_comb begin
    state_next = state;
    unique case (state)
      nes_input_pkg::boot_wait: begin
        // console stays in reset until the first rom arrives
        if (downloading) begin
          state_next = nes_input_pkg::loading;
        end
      end
      nes_input_pkg::loading: begin
        if (!downloading) begin
          state_next = nes_input_pkg::settle;
        end
      end
      nes_input_pkg::settle: begin
        // wait for the post-download hold to run out
        if (!hold_active) begin
          state_next = nes_input_pkg::running;
        end
      end
      nes_input_pkg::running: begin
        if (downloading) begin
          state_next = nes_input_pkg::loading;
        end
      end
      default: begin
        state_next = nes_input_pkg::boot_wait;
      end
    endcase
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state         <= nes_input_pkg::boot_wait;
      downloading_q <= 1'b0;
      core_reset    <= 1'b1;
      loader_reset  <= 1'b1;
    end else begin
      state         <= state_next;
      downloading_q <= downloading;
      // failure and user requests fold into the same console reset
      core_reset    <= (state != nes_input_pkg::running) || loader_fail || user_reset;
      // loader held in reset when idle, and pulsed at download start
      loader_reset  <= !hold_active || (downloading && !downloading_q);
    end
  end

  // console never runs while the sequencer is outside running
  a_core_reset_outside_running: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (state != nes_input_pkg::running) |=> core_reset
  );

  // a download must pass through loading and settle before running
  a_no_boot_skip: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (state == nes_input_pkg::boot_wait) |=> (state != nes_input_pkg::running)
  );

endmodule

`default_nettype wire

// ==== download_hold_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module download_hold_timer (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic downloading,
  input  logic loader_busy,
  output logic hold_active
);

  nes_input_pkg::hold_count_t count;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      count <= '0;
    end else if (downloading) begin
      // reload every cycle of the download
      count <= nes_input_pkg::download_hold_cycles;
    end else if (!loader_busy && (count != '0)) begin
      // stalls while the loader is still busy
      count <= count - 1'b1;
    end
  end

  assign hold_active = (count != '0);

  // an idle counter must stay at zero until the next download
  a_no_wrap: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (count == '0 && !downloading) |=> (count != nes_input_pkg::download_hold_cycles)
  );

endmodule

`default_nettype wire

// ==== joypad_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module joypad_shifter #(
  parameter logic [7:0] port_signature = nes_input_pkg::tap_signature_port1
) (
  input  logic                      clk_ppu_21_47,
  input  logic                      reset_nes,
  input  logic                      strobe,
  input  logic                      port_clock,
  input  nes_input_pkg::pad_buttons_t primary_pad,
  input  nes_input_pkg::pad_buttons_t alternate_pad,
  input  nes_input_pkg::pad_buttons_t tap_pad,
  input  logic                      swap,
  input  logic                      multitap_enabled,
  output logic                      data
);

  nes_input_pkg::joy_frame_t   frame;
  nes_input_pkg::joy_frame_t   frame_load;
  nes_input_pkg::pad_buttons_t first_pad;

  // last sampled level of the port clock line
  logic port_clock_q;
  logic clock_fall;

  // shifts seen since the last load saturate at a full frame
  logic [$clog2(nes_input_pkg::frame_bits+1)-1:0] shift_count;

  assign first_pad = swap ? alternate_pad : primary_pad;

  // multitap puts the extra pad and a signature byte above the first pad
  assign frame_load = multitap_enabled ? {port_signature, tap_pad, first_pad}
                                       : {nes_input_pkg::no_tap_fill, first_pad};

  assign clock_fall = port_clock_q && !port_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      frame        <= '0;
      port_clock_q <= 1'b0;
    end else begin
      port_clock_q <= port_clock;
      // a falling clock edge takes priority over the strobe load
      if (clock_fall) begin
        frame <= {1'b0, frame[nes_input_pkg::frame_bits-1:1]};
      end else if (strobe) begin
        frame <= frame_load;
      end
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_count <= '0;
    end else if (clock_fall) begin
      if (shift_count != nes_input_pkg::frame_bits) begin
        shift_count <= shift_count + 1'b1;
      end
    end else if (strobe) begin
      shift_count <= '0;
    end
  end

  // lsb first onto the serial line
  assign data = frame[0];

  // after a full frame the line reads zeros until the next strobe
  a_frame_drained: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (shift_count == nes_input_pkg::frame_bits) |-> !data
  );

endmodule

`default_nettype wire

// ==== nes_input_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module nes_input_top (
  input  logic                        clk_ppu_21_47,
  input  logic                        reset_nes,
  input  logic                        downloading,
  input  logic                        loader_busy,
  input  logic                        loader_fail,
  input  logic                        user_reset,
  input  nes_input_pkg::pad_buttons_t p1_buttons,
  input  nes_input_pkg::pad_buttons_t p2_buttons,
  input  nes_input_pkg::pad_buttons_t p3_buttons,
  input  nes_input_pkg::pad_buttons_t p4_buttons,
  input  logic                        multitap_enabled,
  input  logic                        swap_controllers,
  input  logic                        joypad_strobe,
  input  logic [1:0]                  joypad_clock,
  output logic                        joypad1_data,
  output logic                        joypad2_data,
  output logic                        core_reset,
  output logic                        loader_reset
);

  // post-download hold from timer to sequencer
  logic hold_active;

  boot_reset_fsm u_boot_reset_fsm (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .downloading   (downloading),
    .hold_active   (hold_active),
    .loader_fail   (loader_fail),
    .user_reset    (user_reset),
    .core_reset    (core_reset),
    .loader_reset  (loader_reset)
  );

  download_hold_timer u_download_hold_timer (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .downloading   (downloading),
    .loader_busy   (loader_busy),
    .hold_active   (hold_active)
  );

  // port 1 carries p1, or p2 when swapped, and p3 on the multitap
  joypad_shifter #(
    .port_signature (nes_input_pkg::tap_signature_port1)
  ) port1_shifter (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .strobe           (joypad_strobe),
    .port_clock       (joypad_clock[0]),
    .primary_pad      (p1_buttons),
    .alternate_pad    (p2_buttons),
    .tap_pad          (p3_buttons),
    .swap             (swap_controllers),
    .multitap_enabled (multitap_enabled),
    .data             (joypad1_data)
  );

  // port 2 mirrors port 1 with p4 on the multitap
  joypad_shifter #(
    .port_signature (nes_input_pkg::tap_signature_port2)
  ) port2_shifter (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .strobe           (joypad_strobe),
    .port_clock       (joypad_clock[1]),
    .primary_pad      (p2_buttons),
    .alternate_pad    (p1_buttons),
    .tap_pad          (p4_buttons),
    .swap             (swap_controllers),
    .multitap_enabled (multitap_enabled),
    .data             (joypad2_data)
  );

endmodule

`default_nettype wire

// ==== tb_nes_input.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_nes_input;

  logic                        clk_ppu_21_47;
  logic                        reset_nes;
  logic                        downloading;
  logic                        loader_busy;
  logic                        loader_fail;
  logic                        user_reset;
  nes_input_pkg::pad_buttons_t p1_buttons;
  nes_input_pkg::pad_buttons_t p2_buttons;
  nes_input_pkg::pad_buttons_t p3_buttons;
  nes_input_pkg::pad_buttons_t p4_buttons;
  logic                        multitap_enabled;
  logic                        swap_controllers;
  logic                        joypad_strobe;
  logic [1:0]                  joypad_clock;
  logic                        joypad1_data;
  logic                        joypad2_data;
  logic                        core_reset;
  logic                        loader_reset;

  // set once the first download has been driven
  logic        download_seen;
  logic [31:0] rng_state;
  int          plain_latency;
  int          busy_latency;
  logic [31:0] rnd;

  nes_input_top dut (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .downloading      (downloading),
    .loader_busy      (loader_busy),
    .loader_fail      (loader_fail),
    .user_reset       (user_reset),
    .p1_buttons       (p1_buttons),
    .p2_buttons       (p2_buttons),
    .p3_buttons       (p3_buttons),
    .p4_buttons       (p4_buttons),
    .multitap_enabled (multitap_enabled),
    .swap_controllers (swap_controllers),
    .joypad_strobe    (joypad_strobe),
    .joypad_clock     (joypad_clock),
    .joypad1_data     (joypad1_data),
    .joypad2_data     (joypad2_data),
    .core_reset       (core_reset),
    .loader_reset     (loader_reset)
  );

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #5 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  task automatic report_error(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("test failed");
    $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("test failed");
    $display("timeout while waiting for %s", what);
    $fatal(1, "stopping on timeout");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // frame as the console should see it lsb first
  function automatic logic [23:0] expected_frame(input logic [7:0] primary,
                                                 input logic [7:0] alternate,
                                                 input logic [7:0] tap,
                                                 input logic [7:0] signature,
                                                 input logic swap, input logic tap_on);
    logic [7:0]  first;
    logic [15:0] upper;
    first = swap ? alternate : primary;
    upper = tap_on ? {signature, tap} : 16'hffff;
    return {upper, first};
  endfunction

  // no console run before the first rom
  a_boot_hold: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    !download_seen |-> core_reset
  ) else report_error("boot hold core_reset", 1, 0);

  // console held throughout a download
  // two cycles of pipeline from running
  a_download_hold: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    downloading |-> ##2 core_reset
  ) else report_error("download core_reset", 1, 0);

  a_request_reset: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (user_reset || loader_fail) |=> core_reset
  ) else report_error("request core_reset", 1, 0);

  a_loader_pulse: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    $rose(downloading) |=> loader_reset
  ) else report_error("download start loader_reset", 1, 0);

  // hold is running two cycles after any download cycle
  a_loader_release: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    downloading |-> ##2 !loader_reset
  ) else report_error("download hold loader_reset", 0, 1);

  // download in two bursts, then count cycles until core_reset drops
  task automatic run_download(input int busy_budget, output int latency);
    int          busy_left;
    logic [31:0] r;
    busy_left     = busy_budget;
    download_seen = 1'b1;
    downloading   = 1'b1;
    repeat (4) @(negedge clk_ppu_21_47);
    downloading = 1'b0;
    repeat (3) @(negedge clk_ppu_21_47);
    // second burst starts while the hold is running
    downloading = 1'b1;
    repeat (8) @(negedge clk_ppu_21_47);
    downloading = 1'b0;
    latency     = 0;
    while (core_reset !== 1'b0) begin
      if (latency >= 700) begin
        report_timeout("core_reset release after download");
      end
      r = next_random();
      if (busy_left > 0 && r[0]) begin
        loader_busy = 1'b1;
        busy_left--;
      end else begin
        loader_busy = 1'b0;
      end
      @(negedge clk_ppu_21_47);
      latency++;
    end
    loader_busy = 1'b0;
  endtask

  task automatic pulse_request(input logic use_fail);
    int cycles;
    assert (core_reset === 1'b0)
      else report_error("request precondition core_reset", 0, core_reset);
    if (use_fail) begin
      loader_fail = 1'b1;
    end else begin
      user_reset = 1'b1;
    end
    @(negedge clk_ppu_21_47);
    loader_fail = 1'b0;
    user_reset  = 1'b0;
    assert (core_reset === 1'b1)
      else report_error("request core_reset high", 1, core_reset);
    cycles = 0;
    while (core_reset !== 1'b0) begin
      if (cycles >= 10) begin
        report_timeout("core_reset release after request");
      end
      @(negedge clk_ppu_21_47);
      cycles++;
    end
  endtask

  // strobe both ports, then clock out a full frame on each
  task automatic read_frames(input string test_name);
    logic [23:0] exp1;
    logic [23:0] exp2;
    int          bit_idx;
    exp1 = expected_frame(p1_buttons, p2_buttons, p3_buttons, 8'h08,
                          swap_controllers, multitap_enabled);
    exp2 = expected_frame(p2_buttons, p1_buttons, p4_buttons, 8'h04,
                          swap_controllers, multitap_enabled);
    joypad_strobe = 1'b1;
    @(negedge clk_ppu_21_47);
    joypad_strobe = 1'b0;
    for (bit_idx = 0; bit_idx < 24; bit_idx++) begin
      assert (joypad1_data === exp1[bit_idx])
        else report_error($sformatf("%s port1 bit %0d", test_name, bit_idx),
                          exp1[bit_idx], joypad1_data);
      assert (joypad2_data === exp2[bit_idx])
        else report_error($sformatf("%s port2 bit %0d", test_name, bit_idx),
                          exp2[bit_idx], joypad2_data);
      joypad_clock = 2'b11;
      @(negedge clk_ppu_21_47);
      joypad_clock = 2'b00;
      @(negedge clk_ppu_21_47);
    end
    assert (joypad1_data === 1'b0)
      else report_error({test_name, " port1 after frame"}, 0, joypad1_data);
    assert (joypad2_data === 1'b0)
      else report_error({test_name, " port2 after frame"}, 0, joypad2_data);
  endtask

  initial begin
    rng_state        = 32'd79;
    download_seen    = 1'b0;
    reset_nes        = 1'b1;
    downloading      = 1'b0;
    loader_busy      = 1'b0;
    loader_fail      = 1'b0;
    user_reset       = 1'b0;
    p1_buttons       = '0;
    p2_buttons       = '0;
    p3_buttons       = '0;
    p4_buttons       = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    joypad_strobe    = 1'b0;
    joypad_clock     = 2'b00;
    repeat (2) @(negedge clk_ppu_21_47);
    reset_nes = 1'b0;

    assert (core_reset === 1'b1) else report_error("reset core_reset", 1, core_reset);
    assert (loader_reset === 1'b1) else report_error("reset loader_reset", 1, loader_reset);
    assert (joypad1_data === 1'b0) else report_error("reset joypad1_data", 0, joypad1_data);
    assert (joypad2_data === 1'b0) else report_error("reset joypad2_data", 0, joypad2_data);

    // boot hold with no rom at all
    repeat (300) @(negedge clk_ppu_21_47);

    run_download(0, plain_latency);
    assert (plain_latency >= 255 && plain_latency <= 260)
      else report_error("post-download latency", 257, plain_latency);

    run_download(40, busy_latency);
    assert (busy_latency >= plain_latency + 40)
      else report_error("busy post-download latency", plain_latency + 40, busy_latency);

    pulse_request(1'b0);
    pulse_request(1'b1);

    // plain pads without multitap
    rnd        = next_random();
    p1_buttons = rnd[7:0];
    p2_buttons = rnd[15:8];
    p3_buttons = rnd[23:16];
    p4_buttons = rnd[31:24];
    @(negedge clk_ppu_21_47);
    read_frames("standard frame");

    for (int frame_idx = 0; frame_idx < 8; frame_idx++) begin
      rnd        = next_random();
      p1_buttons = rnd[7:0];
      p2_buttons = rnd[15:8];
      p3_buttons = rnd[23:16];
      p4_buttons = rnd[31:24];
      rnd        = next_random();
      // first four frames walk every setting pair
      if (frame_idx < 4) begin
        {multitap_enabled, swap_controllers} = frame_idx[1:0];
      end else begin
        {multitap_enabled, swap_controllers} = rnd[1:0];
      end
      @(negedge clk_ppu_21_47);
      read_frames($sformatf("multitap frame %0d", frame_idx));
    end

    repeat (4) @(negedge clk_ppu_21_47);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
nes_input_pkg.sv
boot_reset_fsm.sv
download_hold_timer.sv
joypad_shifter.sv
nes_input_top.sv
tb_nes_input.sv

// ==== Bender.yml ====
package:
  name: nes_input
  description: "NES controller ports with boot and post-download reset sequencing"

dependencies: {}

sources:
  # package first, top level last
  - files:
      - nes_input_pkg.sv
      - boot_reset_fsm.sv
      - download_hold_timer.sv
      - joypad_shifter.sv
      - nes_input_top.sv

  # self-checking testbench, top module tb_nes_input
  - target: test
    files:
      - tb_nes_input.sv
